// ==== source/green_pkg.sv ====
package green_pkg;

    // ========================================
    // Sizes and constants
    // ========================================

    // Word address and data widths
    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;
    // Host command tag, echoed back in the response
    localparam int TAG_W = 4;
    // Raw opcode width on the host channel
    localparam int OP_W = 3;
    // Local memory size in words
    localparam int MEM_DEPTH = 256;
    // Cycles of E4 writes kept for forwarding
    localparam int WRITE_HIST_DEPTH = 3;
    // Depth of the reset retiming chain
    localparam int SYNC_STAGES = 2;
    // Identifier returned by the ID command
    localparam logic [DATA_W-1:0] AFU_ID = 32'h6E5C_A001;

    // ========================================
    // Opcodes and response status
    // ========================================

    // Codes 5 to 7 are undefined and flagged illegal
    typedef enum logic [OP_W-1:0] {
        OP_NOP   = 3'd0,
        OP_READ  = 3'd1,
        OP_WRITE = 3'd2,
        OP_ADD   = 3'd3,
        OP_ID    = 3'd4
    } cmd_op_e;

    typedef enum logic {
        RSP_OK      = 1'b0,
        RSP_ILLEGAL = 1'b1
    } rsp_status_e;

    // ========================================
    // Channel structs
    // ========================================

    // Host request, data is write data or add immediate
    typedef struct packed {
        logic              valid;
        logic [OP_W-1:0]   opcode;
        logic [TAG_W-1:0]  tag;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } host_req_t;

    // Decoded command into the execute pipeline
    typedef struct packed {
        logic              valid;
        cmd_op_e           op;
        logic              illegal;
        logic [TAG_W-1:0]  tag;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } dec_cmd_t;

    // Memory request
    // Read and write come from different stages, so each has its own address
    typedef struct packed {
        logic              rd;
        logic              wr;
        logic [ADDR_W-1:0] addr;
        logic [ADDR_W-1:0] waddr;
        logic [DATA_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic              rd_valid;
        logic [DATA_W-1:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic              valid;
        logic [TAG_W-1:0]  tag;
        rsp_status_e       status;
        logic [DATA_W-1:0] data;
    } exe_out_t;

    typedef struct packed {
        logic              valid;
        logic [TAG_W-1:0]  tag;
        rsp_status_e       status;
        logic [DATA_W-1:0] data;
    } host_rsp_t;

endpackage

// ==== source/reset_resync.sv ====
`timescale 1ns/1ps

module reset_resync (
    input  logic Clk_100,
    input  logic rst_n,
    output logic rst_sync_n
);
    import green_pkg::*;

    // Retiming chain, input enters at bit 0
    logic [SYNC_STAGES-1:0] sync_q;

    // Reset moves one stage per edge in both directions
    always_ff @(posedge Clk_100)
    begin
        sync_q <= {sync_q[SYNC_STAGES-2:0], rst_n};
    end

    // Every block sees the reset from the last flop of the chain
    assign rst_sync_n = sync_q[SYNC_STAGES-1];

endmodule

// ==== source/cmd_decode.sv ====
`timescale 1ns/1ps

module cmd_decode (
    input  logic                 Clk_100,
    input  logic                 rst_n,
    input  green_pkg::host_req_t host_rx,
    output green_pkg::dec_cmd_t  dec_cmd
);
    import green_pkg::*;

    cmd_op_e dec_op;
    logic    dec_illegal;
    logic    dec_valid;

    // ========================================
    // Opcode classification
    // ========================================

    always_comb
    begin
        dec_op      = OP_NOP;
        dec_illegal = 1'b0;
        case (host_rx.opcode)
            OP_NOP, OP_READ, OP_WRITE, OP_ADD, OP_ID:
            begin
                dec_op = cmd_op_e'(host_rx.opcode);
            end
            default:
            begin
                // Undefined code, carried as a no-op marked illegal
                dec_illegal = 1'b1;
            end
        endcase
    end

    // No-ops are dropped here and never reach execute
    assign dec_valid = host_rx.valid && (host_rx.opcode != OP_NOP);

    // ========================================
    // Output register
    // ========================================

    always_ff @(posedge Clk_100)
    begin
        // Payload, qualified by valid
        dec_cmd.op      <= dec_op;
        dec_cmd.illegal <= dec_illegal;
        dec_cmd.tag     <= host_rx.tag;
        dec_cmd.addr    <= host_rx.addr;
        dec_cmd.data    <= host_rx.data;
        if (!rst_n)
        begin
            dec_cmd.valid <= 1'b0;
        end
        else
        begin
            dec_cmd.valid <= dec_valid;
        end
    end

endmodule

// ==== source/cmd_execute.sv ====
`timescale 1ns/1ps

module cmd_execute (
    input  logic                Clk_100,
    input  logic                rst_n,
    input  green_pkg::dec_cmd_t dec_cmd,
    output green_pkg::mem_req_t mem_req,
    input  green_pkg::mem_rsp_t mem_rsp,
    output green_pkg::exe_out_t exe_out
);
    import green_pkg::*;

    // One remembered E4 write
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
    } wr_hist_t;

    // Pipeline registers E2 to E4
    dec_cmd_t e2_q;
    dec_cmd_t e3_q;
    dec_cmd_t e4_q;

    // Index 0 holds the write from the previous cycle
    wr_hist_t hist_q [WRITE_HIST_DEPTH];

    logic              e1_rd;
    logic [DATA_W-1:0] mem_word;
    logic [DATA_W-1:0] e4_data;
    rsp_status_e       e4_status;
    logic              e4_wr;

    // ========================================
    // E1, read issue from the decoded command
    // ========================================

    // Only reads and adds need the stored word
    always_comb
    begin
        e1_rd = dec_cmd.valid && !dec_cmd.illegal
                && (dec_cmd.op == OP_READ || dec_cmd.op == OP_ADD);
    end

    // ========================================
    // E2 to E4 registers
    // ========================================

    always_ff @(posedge Clk_100)
    begin
        e2_q <= dec_cmd;
        e3_q <= e2_q;
        e4_q <= e3_q;
        // Only the valid bits are cleared
        if (!rst_n)
        begin
            e2_q.valid <= 1'b0;
            e3_q.valid <= 1'b0;
            e4_q.valid <= 1'b0;
        end
    end

    // ========================================
    // E4, forwarding and result
    // ========================================

    // Memory data is three writes stale
    // Walk oldest to newest so the newest match wins
    always_comb
    begin
        mem_word = mem_rsp.rd_valid ? mem_rsp.rdata : '0;
        for (int i = WRITE_HIST_DEPTH - 1; i >= 0; i--)
        begin
            if (hist_q[i].valid && hist_q[i].addr == e4_q.addr)
            begin
                mem_word = hist_q[i].data;
            end
        end
    end

    always_comb
    begin
        e4_data   = '0;
        e4_status = RSP_OK;
        e4_wr     = 1'b0;
        if (e4_q.illegal)
        begin
            // Zero data, no memory update
            e4_status = RSP_ILLEGAL;
        end
        else
        begin
            case (e4_q.op)
                OP_READ:  e4_data = mem_word;
                OP_WRITE:
                begin
                    e4_data = e4_q.data;
                    e4_wr   = e4_q.valid;
                end
                OP_ADD:
                begin
                    // Wraps modulo 2^32
                    e4_data = mem_word + e4_q.data;
                    e4_wr   = e4_q.valid;
                end
                OP_ID:    e4_data = AFU_ID;
                default:  e4_data = '0;
            endcase
        end
    end

    // Read from E1, write from E4, same cycle
    always_comb
    begin
        mem_req.rd    = e1_rd;
        mem_req.addr  = dec_cmd.addr;
        mem_req.wr    = e4_wr;
        mem_req.waddr = e4_q.addr;
        mem_req.wdata = e4_data;
    end

    // ========================================
    // Write history and output register
    // ========================================

    always_ff @(posedge Clk_100)
    begin
        hist_q[0].addr <= e4_q.addr;
        hist_q[0].data <= e4_data;
        for (int i = 1; i < WRITE_HIST_DEPTH; i++)
        begin
            hist_q[i] <= hist_q[i-1];
        end
        if (!rst_n)
        begin
            for (int i = 0; i < WRITE_HIST_DEPTH; i++)
            begin
                hist_q[i].valid <= 1'b0;
            end
        end
        else
        begin
            hist_q[0].valid <= e4_wr;
        end
    end

    always_ff @(posedge Clk_100)
    begin
        exe_out.tag    <= e4_q.tag;
        exe_out.status <= e4_status;
        exe_out.data   <= e4_data;
        if (!rst_n)
        begin
            exe_out.valid <= 1'b0;
        end
        else
        begin
            exe_out.valid <= e4_q.valid;
        end
    end

endmodule

// ==== source/mem_bridge.sv ====
`timescale 1ns/1ps

module mem_bridge (
    input  logic                Clk_100,
    input  logic                rst_n,
    input  green_pkg::mem_req_t up_req,
    output green_pkg::mem_rsp_t up_rsp,
    output green_pkg::mem_req_t dn_req,
    input  green_pkg::mem_rsp_t dn_rsp
);

    // ========================================
    // Request path toward the bank
    // ========================================

    always_ff @(posedge Clk_100)
    begin
        dn_req.addr  <= up_req.addr;
        dn_req.waddr <= up_req.waddr;
        dn_req.wdata <= up_req.wdata;
        if (!rst_n)
        begin
            dn_req.rd <= 1'b0;
            dn_req.wr <= 1'b0;
        end
        else
        begin
            dn_req.rd <= up_req.rd;
            dn_req.wr <= up_req.wr;
        end
    end

    // ========================================
    // Response path back to execute
    // ========================================

    always_ff @(posedge Clk_100)
    begin
        up_rsp.rdata <= dn_rsp.rdata;
        if (!rst_n)
        begin
            up_rsp.rd_valid <= 1'b0;
        end
        else
        begin
            up_rsp.rd_valid <= dn_rsp.rd_valid;
        end
    end

endmodule

// ==== source/local_mem_bank.sv ====
`timescale 1ns/1ps

module local_mem_bank (
    input  logic                Clk_100,
    input  green_pkg::mem_req_t bank_req,
    output green_pkg::mem_rsp_t bank_rsp
);
    import green_pkg::*;

    // Word array, contents undefined after power-up
    logic [DATA_W-1:0] mem_q [MEM_DEPTH];

    // Write port
    always_ff @(posedge Clk_100)
    begin
        if (bank_req.wr)
        begin
            mem_q[bank_req.waddr] <= bank_req.wdata;
        end
    end

    // Registered read port
    // Same-address write in this cycle is not seen, old word returned
    always_ff @(posedge Clk_100)
    begin
        if (bank_req.rd)
        begin
            bank_rsp.rdata <= mem_q[bank_req.addr];
        end
        bank_rsp.rd_valid <= bank_req.rd;
    end

endmodule

// ==== source/rsp_result.sv ====
`timescale 1ns/1ps

module rsp_result (
    input  logic                 Clk_100,
    input  logic                 rst_n,
    input  green_pkg::exe_out_t  exe_out,
    output green_pkg::host_rsp_t host_tx
);

    // ========================================
    // Host response register
    // ========================================

    // Fields are zero whenever no response is sent
    always_ff @(posedge Clk_100)
    begin
        if (!rst_n)
        begin
            host_tx <= '0;
        end
        else if (exe_out.valid)
        begin
            host_tx.valid  <= 1'b1;
            host_tx.tag    <= exe_out.tag;
            host_tx.status <= exe_out.status;
            host_tx.data   <= exe_out.data;
        end
        else
        begin
            // Idle cycle, clear the whole port
            host_tx <= '0;
        end
    end

endmodule

// ==== source/green_shell.sv ====
`timescale 1ns/1ps

module green_shell (
    input  logic                 Clk_100,
    input  logic                 rst_n,
    input  green_pkg::host_req_t host_rx,
    output green_pkg::host_rsp_t host_tx
);
    import green_pkg::*;

    logic     rst_sync_n;
    dec_cmd_t dec_cmd;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;
    mem_req_t bank_req;
    mem_rsp_t bank_rsp;
    exe_out_t exe_out;

    // ========================================
    // Reset retiming
    // ========================================

    reset_resync i_reset_resync (
        .Clk_100    (Clk_100),
        .rst_n      (rst_n),
        .rst_sync_n (rst_sync_n)
    );

    // ========================================
    // Accelerator pipeline
    // ========================================

    cmd_decode i_cmd_decode (
        .Clk_100 (Clk_100),
        .rst_n   (rst_sync_n),
        .host_rx (host_rx),
        .dec_cmd (dec_cmd)
    );

    cmd_execute i_cmd_execute (
        .Clk_100 (Clk_100),
        .rst_n   (rst_sync_n),
        .dec_cmd (dec_cmd),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp),
        .exe_out (exe_out)
    );

    rsp_result i_rsp_result (
        .Clk_100 (Clk_100),
        .rst_n   (rst_sync_n),
        .exe_out (exe_out),
        .host_tx (host_tx)
    );

    // ========================================
    // Local memory behind the bridge
    // ========================================

    mem_bridge i_mem_bridge (
        .Clk_100 (Clk_100),
        .rst_n   (rst_sync_n),
        .up_req  (mem_req),
        .up_rsp  (mem_rsp),
        .dn_req  (bank_req),
        .dn_rsp  (bank_rsp)
    );

    // Array has no reset
    local_mem_bank i_local_mem_bank (
        .Clk_100  (Clk_100),
        .bank_req (bank_req),
        .bank_rsp (bank_rsp)
    );

endmodule

// ==== verification/green_shell_properties.sv ====
`timescale 1ns/1ps

module green_shell_properties (
    input logic                 Clk_100,
    input logic                 rst_n,
    input logic                 rst_sync_n,
    input green_pkg::host_req_t host_rx,
    input green_pkg::host_rsp_t host_tx
);
    import green_pkg::*;

    // Failed assertions, read back by the testbench
    int fail_cnt = 0;

    // ========================================
    // Reset
    // ========================================

    // Retimed reset reaches the response register three edges after rst_n
    reset_idle: assert property (@(posedge Clk_100)
        (!rst_n && $past(!rst_n, 1) && $past(!rst_n, 2) && $past(!rst_n, 3))
        |-> !host_tx.valid)
    else
    begin
        fail_cnt++;
        $error("host_tx.valid high while rst_n held low");
    end

    // ========================================
    // Response port
    // ========================================

    rsp_known: assert property (@(posedge Clk_100)
        host_tx.valid |-> !$isunknown(host_tx))
    else
    begin
        fail_cnt++;
        $error("host_tx carries unknown bits with valid high");
    end

    // Register loads at the fifth edge, seen at the sixth sample
    rsp_latency: assert property (@(posedge Clk_100) disable iff (!rst_n)
        (rst_sync_n && host_rx.valid && host_rx.opcode != OP_NOP) |-> ##6 host_tx.valid)
    else
    begin
        fail_cnt++;
        $error("no host_tx.valid five cycles after a command");
    end

endmodule

bind green_shell green_shell_properties i_green_shell_properties (
    .Clk_100    (Clk_100),
    .rst_n      (rst_n),
    .rst_sync_n (rst_sync_n),
    .host_rx    (host_rx),
    .host_tx    (host_tx)
);

// ==== verification/green_shell_tb.sv ====
`timescale 1ns/1ps

module green_shell_tb;
    import green_pkg::*;

    // ========================================
    // Constants and state
    // ========================================

    // Edges from command sample to response register
    localparam int RSP_LAT = 5;
    // Far above the length of the whole test sequence
    localparam int MAX_CYCLES = 2000;
    localparam int DRAIN_LIMIT = 20;
    localparam int N_WR = 20;

    logic      Clk_100;
    logic      rst_n;
    host_req_t host_rx;
    host_rsp_t host_tx;

    // Reference memory updated in command order
    logic [DATA_W-1:0] ref_mem [MEM_DEPTH];
    logic [31:0]       lcg_state;
    logic [TAG_W-1:0]  next_tag;
    int cycle_cnt = 0;
    int check_cnt = 0;
    int error_cnt = 0;
    int rsp_seen = 0;

    // Expected responses with the oldest command at the front
    logic [TAG_W-1:0]  exp_tag_q [$];
    logic              exp_status_q [$];
    logic [DATA_W-1:0] exp_data_q [$];
    int                exp_due_q [$];

    green_shell i_green_shell (
        .Clk_100 (Clk_100),
        .rst_n   (rst_n),
        .host_rx (host_rx),
        .host_tx (host_tx)
    );

    initial
    begin
        Clk_100 = 1'b0;
        forever
        begin
            #10 Clk_100 = ~Clk_100;
        end
    end

    // Edge count and run limit
    always @(posedge Clk_100)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES)
        begin
            $display("Run stopped after %0d cycles without finishing the tests", cycle_cnt);
            $display("sim failed");
            $finish;
        end
    end

    // Linear congruential generator
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // ========================================
    // Response monitor
    // ========================================

    task automatic compare_rsp();
        logic [TAG_W-1:0]  tag;
        logic              status;
        logic [DATA_W-1:0] data;
        int                due;
        tag    = exp_tag_q.pop_front();
        status = exp_status_q.pop_front();
        data   = exp_data_q.pop_front();
        due    = exp_due_q.pop_front();
        check_cnt++;
        if (due != cycle_cnt)
        begin
            $display("Response tag %h came at cycle %0d, due at cycle %0d", tag, cycle_cnt, due);
            error_cnt++;
        end
        if (host_tx.tag !== tag)
        begin
            $display("Error host_tx.tag: expected %h, got %h", tag, host_tx.tag);
            error_cnt++;
        end
        if (host_tx.status !== status)
        begin
            $display("Error host_tx.status: expected %h, got %h", status, host_tx.status);
            error_cnt++;
        end
        if (host_tx.data !== data)
        begin
            $display("Error host_tx.data: expected %h, got %h", data, host_tx.data);
            error_cnt++;
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge Clk_100)
    begin
        if (host_tx.valid === 1'b1)
        begin
            rsp_seen++;
            if (exp_tag_q.size() == 0)
            begin
                $display("Response tag %h arrived with no command pending", host_tx.tag);
                error_cnt++;
            end
            else
            begin
                compare_rsp();
            end
        end
        else
        begin
            // An idle port carries all zero fields
            if (host_tx.valid === 1'b0 && host_tx !== '0)
            begin
                $display("Error host_tx: expected 0 while idle, got %h", host_tx);
                error_cnt++;
            end
            if (exp_due_q.size() > 0 && exp_due_q[0] <= cycle_cnt)
            begin
                $display("No response for tag %h, due at cycle %0d", exp_tag_q[0], exp_due_q[0]);
                error_cnt++;
                void'(exp_tag_q.pop_front());
                void'(exp_status_q.pop_front());
                void'(exp_data_q.pop_front());
                void'(exp_due_q.pop_front());
            end
        end
    end

    // ========================================
    // Command driver and reference model
    // ========================================

    task automatic issue(input logic [2:0] opcode, input logic [ADDR_W-1:0] addr,
                         input logic [DATA_W-1:0] data);
        logic [DATA_W-1:0] exp_data;
        logic              exp_status;
        exp_data   = '0;
        exp_status = RSP_OK;
        case (opcode)
            OP_NOP:   exp_data = '0;
            OP_READ:  exp_data = ref_mem[addr];
            OP_WRITE:
            begin
                ref_mem[addr] = data;
                exp_data      = data;
            end
            OP_ADD:
            begin
                // 32-bit sum wraps
                ref_mem[addr] = ref_mem[addr] + data;
                exp_data      = ref_mem[addr];
            end
            OP_ID:    exp_data = AFU_ID;
            default:  exp_status = RSP_ILLEGAL;
        endcase
        @(negedge Clk_100);
        host_rx.valid  = 1'b1;
        host_rx.opcode = opcode;
        host_rx.tag    = next_tag;
        host_rx.addr   = addr;
        host_rx.data   = data;
        // No-ops get no response and use no tag
        if (opcode != OP_NOP)
        begin
            exp_tag_q.push_back(next_tag);
            exp_status_q.push_back(exp_status);
            exp_data_q.push_back(exp_data);
            exp_due_q.push_back(cycle_cnt + 1 + RSP_LAT);
            next_tag++;
        end
    endtask

    // Stop driving and wait for all pending responses
    task automatic drain();
        int waited;
        waited = 0;
        @(negedge Clk_100);
        host_rx.valid = 1'b0;
        while (exp_tag_q.size() > 0 && waited < DRAIN_LIMIT)
        begin
            @(negedge Clk_100);
            waited++;
        end
        if (exp_tag_q.size() > 0)
        begin
            $display("%0d responses still pending after %0d cycles", exp_tag_q.size(), waited);
            error_cnt++;
        end
    endtask

    task automatic expect_idle();
        check_cnt++;
        if (host_tx.valid !== 1'b0)
        begin
            $display("Error host_tx.valid: expected 0, got %h", host_tx.valid);
            error_cnt++;
        end
    endtask

    task automatic report(input string name, input int errs_before);
        if (error_cnt == errs_before)
        begin
            $display("Test %s finished, no errors", name);
        end
        else
        begin
            $display("Test %s finished, %0d errors", name, error_cnt - errs_before);
        end
    endtask

    // ========================================
    // Tests
    // ========================================

    task automatic reset_sequence();
        int errs;
        errs  = error_cnt;
        rst_n = 1'b0;
        for (int i = 0; i < 5; i++)
        begin
            @(negedge Clk_100);
            // Retimed reset clears the response register by the third edge
            if (i >= 2)
            begin
                expect_idle();
            end
        end
        rst_n = 1'b1;
        for (int i = 0; i < 6; i++)
        begin
            @(negedge Clk_100);
            expect_idle();
        end
        report("reset", errs);
    endtask

    task automatic write_then_read();
        logic [ADDR_W-1:0] addrs [N_WR];
        logic [31:0]       r;
        int                errs;
        errs = error_cnt;
        for (int i = 0; i < N_WR; i++)
        begin
            r        = next_rand();
            addrs[i] = r[23:16];
            issue(OP_WRITE, addrs[i], next_rand());
        end
        for (int i = 0; i < N_WR; i++)
        begin
            issue(OP_READ, addrs[i], '0);
        end
        drain();
        report("write_read", errs);
    endtask

    task automatic id_and_add();
        logic [ADDR_W-1:0] a;
        logic [31:0]       r;
        int                errs;
        errs = error_cnt;
        r    = next_rand();
        a    = r[23:16];
        issue(OP_ID, a, next_rand());
        issue(OP_WRITE, a, 32'h0000_1234);
        issue(OP_ADD, a, next_rand());
        // Sum passes 2^32
        issue(OP_WRITE, a + 8'd1, 32'hFFFF_FFF0);
        issue(OP_ADD, a + 8'd1, 32'h0000_0025);
        drain();
        issue(OP_READ, a, '0);
        issue(OP_READ, a + 8'd1, '0);
        issue(OP_ID, a, '0);
        drain();
        report("id_add", errs);
    endtask

    task automatic dependent_burst();
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-1:0] b;
        logic [ADDR_W-1:0] c;
        logic [31:0]       r;
        int                errs;
        errs = error_cnt;
        r    = next_rand();
        a    = r[23:16];
        b    = a ^ 8'h55;
        c    = a ^ 8'hAA;
        // Same address every cycle so reads hit the write history
        issue(OP_WRITE, a, next_rand());
        issue(OP_ADD, a, next_rand());
        issue(OP_ADD, a, next_rand());
        issue(OP_ADD, a, next_rand());
        issue(OP_READ, a, '0);
        // Spread over three addresses for longer match distances
        issue(OP_WRITE, b, next_rand());
        issue(OP_WRITE, c, next_rand());
        issue(OP_ADD, a, next_rand());
        issue(OP_ADD, b, next_rand());
        issue(OP_ADD, c, next_rand());
        issue(OP_ADD, a, next_rand());
        issue(OP_READ, b, '0);
        issue(OP_READ, a, '0);
        issue(OP_READ, c, '0);
        drain();
        report("dependent", errs);
    endtask

    task automatic illegal_and_nop();
        logic [ADDR_W-1:0] a;
        logic [31:0]       r;
        int                seen;
        int                errs;
        errs = error_cnt;
        r    = next_rand();
        a    = r[23:16];
        issue(OP_WRITE, a, next_rand());
        for (int op = 5; op < 8; op++)
        begin
            issue(op[2:0], a, next_rand());
        end
        issue(OP_READ, a, '0);
        // No-op inside a burst leaves a gap in the response train
        issue(OP_NOP, a, next_rand());
        issue(OP_READ, a, '0);
        drain();
        seen = rsp_seen;
        issue(OP_NOP, a, next_rand());
        drain();
        repeat (RSP_LAT + 3) @(negedge Clk_100);
        check_cnt++;
        if (rsp_seen != seen)
        begin
            $display("A lone no-op produced %0d response pulses", rsp_seen - seen);
            error_cnt++;
        end
        report("illegal_nop", errs);
    endtask

    // ========================================
    // Sequence
    // ========================================

    initial
    begin
        lcg_state = 32'hfca5;
        next_tag  = '0;
        rst_n     = 1'b0;
        host_rx   = '0;
        reset_sequence();
        write_then_read();
        id_and_add();
        dependent_burst();
        illegal_and_nop();
        // Bound assertion failures add to the error count
        error_cnt += i_green_shell.i_green_shell_properties.fail_cnt;
        $display("Checks %0d, errors %0d, responses %0d", check_cnt, error_cnt, rsp_seen);
        if (error_cnt == 0)
        begin
            $display("sim passed");
        end
        else
        begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
source/green_pkg.sv
source/reset_resync.sv
source/cmd_decode.sv
source/cmd_execute.sv
source/mem_bridge.sv
source/local_mem_bank.sv
source/rsp_result.sv
source/green_shell.sv
verification/green_shell_properties.sv
verification/green_shell_tb.sv

// ==== Bender.yml ====
package:
  name: green_shell

sources:
  - source/green_pkg.sv
  - source/reset_resync.sv
  - source/cmd_decode.sv
  - source/cmd_execute.sv
  - source/mem_bridge.sv
  - source/local_mem_bank.sv
  - source/rsp_result.sv
  - source/green_shell.sv
  - target: test
    files:
      - verification/green_shell_properties.sv
      - verification/green_shell_tb.sv
